// ==== Bender.yml ====
package:
  name: usb2_proto

sources:
  - hw/usb2_pkg.sv
  - hw/usb2_buf_if.sv
  - hw/usb2_ep_buf.sv
  - hw/usb2_setup_ctr.sv
  - hw/usb2_ep0_ctrl.sv
  - hw/usb2_protocol.sv
  - target: test
    files:
      - bench/usb2_protocol_tb.sv

// ==== bench/usb2_protocol_tb.sv ====
////////////////////
// Testbench for the single clock USB 2.0 protocol layer
// Packet lengths stay within 8 to 24 bytes, so only low buffer addresses are used
// Setup packets carry only the request fields that endpoint 0 decodes
////////////////////

`default_nettype none

module usb2_protocol_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import usb2_pkg::*;

	localparam int ROUNDS   = 4;
	localparam int TOGGLES  = 24;
	localparam int TXNS     = 4 * ROUNDS + 2 + 3 * ROUNDS + TOGGLES;
	localparam int WD_CYCLES = TXNS * 40 + 200;

	logic              phy_clk;
	logic              reset_2;
	logic [3:0]        sel_endp;
	logic [BUF_AW-1:0] buf_in_addr, buf_out_addr, ext_buf_in_addr, ext_buf_out_addr;
	logic [7:0]        buf_in_data, buf_out_q, ext_buf_in_data, ext_buf_out_q;
	logic              buf_in_wren, buf_in_ready, buf_in_commit, buf_in_commit_ack;
	logic              ext_buf_in_wren, ext_buf_in_ready, ext_buf_in_commit;
	logic              ext_buf_in_commit_ack;
	logic [LEN_W-1:0]  buf_in_commit_len, buf_out_len, ext_buf_in_commit_len, ext_buf_out_len;
	logic              buf_out_hasdata, buf_out_arm, buf_out_arm_ack;
	logic              ext_buf_out_hasdata, ext_buf_out_arm, ext_buf_out_arm_ack;
	logic [1:0]        endp_mode, data_toggle;
	logic              data_toggle_act, vend_req_act, err_setup_pkt;
	logic [7:0]        vend_req_request;
	logic [15:0]       vend_req_val;
	logic [6:0]        dev_addr;

	// Reference model state
	logic [7:0]  mem1 [0:511];
	logic [7:0]  mem2 [0:511];
	int          len1, len2;
	logic [1:0]  tog [0:2];
	logic [6:0]  exp_addr;
	logic [7:0]  exp_req;
	logic [15:0] exp_val;

	usb2_protocol UUT (.*);

	initial begin
		phy_clk = 1'b0;
		forever #2 phy_clk = ~phy_clk;
	end

	initial begin
		repeat (WD_CYCLES) @(posedge phy_clk);
		$display("Timeout: the run did not finish within %0d clock cycles", WD_CYCLES);
		$display("TEST FAILED");
		$fatal(1, "watchdog expired");
	end

	task automatic check(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Error at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
			$display("TEST FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// Land 1 ns after the rising edge, where inputs are driven
	task automatic tick;
		@(posedge phy_clk);
		#1;
	endtask

	// Let combinational outputs follow freshly driven inputs
	task automatic settle;
		#2;
	endtask

	////////////////////
	// Bulk endpoints
	////////////////////

	task automatic fill_ep2(input int len);
		logic [7:0] d;
		sel_endp = 4'd2;
		settle;
		check("endp_mode", endp_mode, EP_MODE_BULK);
		check("buf_in_ready", buf_in_ready, 1);
		tick;
		for (int i = 0; i < len; i++) begin
			d = $urandom;
			buf_in_addr = i;
			buf_in_data = d;
			buf_in_wren = 1'b1;
			tick;
			mem2[i] = d;
		end
		buf_in_wren = 1'b0;
		buf_in_commit = 1'b1;
		buf_in_commit_len = len;
		tick;
		buf_in_commit = 1'b0;
		while (!buf_in_commit_ack) tick;
		len2 = len;
		check("buf_in_ready", buf_in_ready, 0);
		// Full buffer drops these
		for (int i = 0; i < 4; i++) begin
			buf_in_addr = i;
			buf_in_data = $urandom;
			buf_in_wren = 1'b1;
			tick;
		end
		buf_in_wren = 1'b0;
	endtask

	task automatic drain_ep2;
		check("ext_buf_out_hasdata", ext_buf_out_hasdata, 1);
		check("ext_buf_out_len", ext_buf_out_len, len2);
		for (int i = 0; i < len2; i++) begin
			ext_buf_out_addr = i;
			tick;
			check("ext_buf_out_q", ext_buf_out_q, mem2[i]);
		end
		ext_buf_out_arm = 1'b1;
		tick;
		ext_buf_out_arm = 1'b0;
		while (!ext_buf_out_arm_ack) tick;
		check("ext_buf_out_hasdata", ext_buf_out_hasdata, 0);
	endtask

	task automatic fill_ep1(input int len);
		logic [7:0] d;
		check("ext_buf_in_ready", ext_buf_in_ready, 1);
		for (int i = 0; i < len; i++) begin
			d = $urandom;
			ext_buf_in_addr = i;
			ext_buf_in_data = d;
			ext_buf_in_wren = 1'b1;
			tick;
			mem1[i] = d;
		end
		ext_buf_in_wren = 1'b0;
		ext_buf_in_commit = 1'b1;
		ext_buf_in_commit_len = len;
		tick;
		ext_buf_in_commit = 1'b0;
		while (!ext_buf_in_commit_ack) tick;
		len1 = len;
		check("ext_buf_in_ready", ext_buf_in_ready, 0);
		for (int i = 0; i < 4; i++) begin
			ext_buf_in_addr = i;
			ext_buf_in_data = $urandom;
			ext_buf_in_wren = 1'b1;
			tick;
		end
		ext_buf_in_wren = 1'b0;
	endtask

	task automatic drain_ep1;
		sel_endp = 4'd1;
		settle;
		check("endp_mode", endp_mode, EP_MODE_BULK);
		check("buf_out_hasdata", buf_out_hasdata, 1);
		check("buf_out_len", buf_out_len, len1);
		tick;
		for (int i = 0; i < len1; i++) begin
			buf_out_addr = i;
			tick;
			check("buf_out_q", buf_out_q, mem1[i]);
		end
		buf_out_arm = 1'b1;
		tick;
		buf_out_arm = 1'b0;
		while (!buf_out_arm_ack) tick;
		check("buf_out_hasdata", buf_out_hasdata, 0);
	endtask

	// Needs endpoint 1 full and endpoint 2 empty
	task automatic check_isolation;
		sel_endp = 4'd1;
		settle;
		check("buf_in_ready", buf_in_ready, 0);
		tick;
		for (int i = 0; i < 8; i++) begin
			buf_in_addr = i;
			buf_in_data = $urandom;
			buf_in_wren = 1'b1;
			tick;
		end
		buf_in_wren = 1'b0;
		buf_in_commit = 1'b1;
		buf_in_commit_len = 8;
		tick;
		buf_in_commit = 1'b0;
		check("buf_in_commit_ack", buf_in_commit_ack, 0);
		// Endpoint 0 must not have taken that commit
		sel_endp = 4'd0;
		settle;
		check("buf_in_ready", buf_in_ready, 1);
		tick;
		sel_endp = 4'd1;
		repeat (14) begin
			tick;
			check("err_setup_pkt", err_setup_pkt, 0);
			check("vend_req_act", vend_req_act, 0);
		end
		check("dev_addr", dev_addr, exp_addr);
		check("ext_buf_out_hasdata", ext_buf_out_hasdata, 0);
		sel_endp = 4'd3;
		settle;
		check("buf_in_ready", buf_in_ready, 0);
		check("buf_in_commit_ack", buf_in_commit_ack, 0);
		check("buf_out_q", buf_out_q, 0);
		check("buf_out_len", buf_out_len, 0);
		check("buf_out_hasdata", buf_out_hasdata, 0);
		check("buf_out_arm_ack", buf_out_arm_ack, 0);
		check("data_toggle", data_toggle, 0);
		check("endp_mode", endp_mode, EP_MODE_CONTROL);
		tick;
		// Endpoint 2 RAM keeps the last packet
		for (int i = 0; i < 8; i++) begin
			ext_buf_out_addr = i;
			tick;
			check("ext_buf_out_q", ext_buf_out_q, mem2[i]);
		end
	endtask

	////////////////////
	// Endpoint 0
	////////////////////

	// head holds bytes 3..0, the rest of the packet is random
	task automatic send_setup(input logic [31:0] head, input int len,
		output int nv, output int ne);
		sel_endp = 4'd0;
		settle;
		check("endp_mode", endp_mode, EP_MODE_CONTROL);
		check("buf_in_ready", buf_in_ready, 1);
		tick;
		for (int i = 0; i < 8; i++) begin
			buf_in_addr = i;
			buf_in_data = (i < 4) ? head[8*i +: 8] : 8'($urandom);
			buf_in_wren = 1'b1;
			tick;
		end
		buf_in_wren = 1'b0;
		buf_in_commit = 1'b1;
		buf_in_commit_len = len;
		tick;
		buf_in_commit = 1'b0;
		check("buf_in_commit_ack", buf_in_commit_ack, 1);
		nv = 0;
		ne = 0;
		while (!buf_in_ready) begin
			tick;
			if (vend_req_act) nv++;
			if (err_setup_pkt) ne++;
		end
	endtask

	task automatic run_setups;
		logic [15:0] wv;
		logic [7:0]  req;
		logic [7:0]  rt;
		int          nv, ne, len;
		// SET_ADDRESS
		wv = $urandom;
		rt = {1'($urandom), 2'b00, 5'($urandom)};
		send_setup({wv[15:8], wv[7:0], REQ_SET_ADDRESS, rt}, 8, nv, ne);
		exp_addr = wv[6:0];
		check("vend_req_act pulses", nv, 0);
		check("err_setup_pkt pulses", ne, 0);
		check("dev_addr", dev_addr, exp_addr);
		// Vendor request
		wv = $urandom;
		req = $urandom;
		rt = {1'($urandom), 2'b10, 5'($urandom)};
		send_setup({wv[15:8], wv[7:0], req, rt}, 8, nv, ne);
		exp_req = req;
		exp_val = wv;
		check("vend_req_act pulses", nv, 1);
		check("err_setup_pkt pulses", ne, 0);
		check("vend_req_request", vend_req_request, exp_req);
		check("vend_req_val", vend_req_val, exp_val);
		check("dev_addr", dev_addr, exp_addr);
		// Wrong length with a vendor header
		len = $urandom_range(0, 63);
		if (len == SETUP_LEN) len = 9;
		send_setup({16'($urandom), 8'($urandom), 8'h40}, len, nv, ne);
		check("vend_req_act pulses", nv, 0);
		check("err_setup_pkt pulses", ne, 1);
		check("dev_addr", dev_addr, exp_addr);
		check("vend_req_request", vend_req_request, exp_req);
		check("vend_req_val", vend_req_val, exp_val);
	endtask

	task automatic run_toggles;
		int s;
		for (int k = 0; k < TOGGLES; k++) begin
			s = $urandom_range(0, 4);
			sel_endp = s;
			data_toggle_act = 1'b1;
			tick;
			data_toggle_act = 1'b0;
			if (s < 3) tog[s] = tog[s] ^ 2'd1;
			for (int e = 0; e < 5; e++) begin
				sel_endp = e;
				settle;
				check("data_toggle", data_toggle, (e < 3) ? tog[e] : 2'd0);
				tick;
			end
		end
	endtask

	initial begin
		int seed_val;
		seed_val = $urandom(32'h5273);
		reset_2 = 1'b0;
		sel_endp = 4'd0;
		{buf_in_addr, buf_in_data, buf_in_wren, buf_in_commit, buf_in_commit_len} = '0;
		{buf_out_addr, buf_out_arm, data_toggle_act} = '0;
		{ext_buf_in_addr, ext_buf_in_data, ext_buf_in_wren} = '0;
		{ext_buf_in_commit, ext_buf_in_commit_len, ext_buf_out_addr, ext_buf_out_arm} = '0;
		for (int e = 0; e < 3; e++) tog[e] = 2'd0;
		exp_addr = '0;
		exp_req = '0;
		exp_val = '0;
		repeat (4) @(posedge phy_clk);
		#1;
		reset_2 = 1'b1;
		check("buf_in_ready", buf_in_ready, 1);
		check("buf_in_commit_ack", buf_in_commit_ack, 0);
		check("ext_buf_out_hasdata", ext_buf_out_hasdata, 0);
		check("dev_addr", dev_addr, 0);
		check("vend_req_act", vend_req_act, 0);
		check("err_setup_pkt", err_setup_pkt, 0);
		check("data_toggle", data_toggle, 0);
		for (int r = 0; r < ROUNDS; r++) begin
			fill_ep2($urandom_range(8, 24));
			drain_ep2;
		end
		for (int r = 0; r < ROUNDS; r++) begin
			fill_ep1($urandom_range(8, 24));
			if (r == 0) check_isolation;
			drain_ep1;
		end
		for (int r = 0; r < ROUNDS; r++) run_setups;
		run_toggles;
		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hw/usb2_buf_if.sv ====
////////////////////
// One endpoint buffer, write group and read group
// Data is 8 bits wide, AW sets the address width
////////////////////

`default_nettype none

interface usb2_buf_if #(parameter int AW = usb2_pkg::BUF_AW) ();
	import usb2_pkg::*;

	// Write group
	logic [AW-1:0]    wr_addr;
	logic [7:0]       wr_data;
	logic             wr_en;
	logic             ready;
	logic             commit;
	logic [LEN_W-1:0] commit_len;
	logic             commit_ack;

	// Read group
	logic [AW-1:0]    rd_addr;
	logic [7:0]       q;
	logic [LEN_W-1:0] len;
	logic             hasdata;
	logic             arm;
	logic             arm_ack;

	modport buffer (
		input  wr_addr, wr_data, wr_en, commit, commit_len, rd_addr, arm,
		output ready, commit_ack, q, len, hasdata, arm_ack
	);
	modport writer (
		output wr_addr, wr_data, wr_en, commit, commit_len,
		input  ready, commit_ack
	);
	modport reader (output rd_addr, arm, input q, len, hasdata, arm_ack);

endinterface

`default_nettype wire

// ==== hw/usb2_ep0_ctrl.sv ====
////////////////////
// Endpoint 0 SETUP decoder
// Only SET_ADDRESS and vendor requests act, others are dropped
// No data or status stage, the buffer is rearmed after decode
////////////////////

`default_nettype none

module usb2_ep0_ctrl (
	input  logic        phy_clk,
	input  logic        reset_2,
	usb2_buf_if.reader  rd,
	output logic        vend_req_act,
	output logic [7:0]  vend_req_request,
	output logic [15:0] vend_req_val,
	output logic [6:0]  dev_addr,
	output logic        err_setup_pkt
);
	import usb2_pkg::*;

	ep0_state_e        state;
	logic              ctr_start;
	logic              ctr_busy;
	logic              ctr_done;
	logic [EP0_AW-1:0] ctr_addr;
	logic [EP0_AW-1:0] addr_d;
	logic              cap_vld;
	// bmRequestType, bRequest, wValue low, wValue high
	logic [7:0]        setup_b [0:3];
	req_type_e         req_type;

	assign ctr_start  = (state == ST_CHECK) && (rd.len == LEN_W'(SETUP_LEN));
	assign rd.rd_addr = ctr_addr;
	assign rd.arm     = (state == ST_RELEASE);
	assign req_type   = req_type_e'(setup_b[0][6:5]);

	usb2_setup_ctr u_setup_ctr (
		.phy_clk (phy_clk),
		.reset_2 (reset_2),
		.start   (ctr_start),
		.addr    (ctr_addr),
		.busy    (ctr_busy),
		.done    (ctr_done)
	);

	////////////////////
	// Byte capture
	////////////////////

	always_ff @(posedge phy_clk) begin
		if (!reset_2) begin
			cap_vld <= 1'b0;
		end else begin
			cap_vld <= ctr_busy;
		end
	end

	// q lags rd_addr by one cycle, so use the delayed address
	always_ff @(posedge phy_clk) begin
		addr_d <= ctr_addr;
		if (cap_vld && addr_d < EP0_AW'(4)) begin
			setup_b[addr_d[1:0]] <= rd.q;
		end
	end

	////////////////////
	// Request FSM
	////////////////////

	always_ff @(posedge phy_clk) begin
		if (!reset_2) begin
			state            <= ST_IDLE;
			vend_req_act     <= 1'b0;
			vend_req_request <= '0;
			vend_req_val     <= '0;
			dev_addr         <= '0;
			err_setup_pkt    <= 1'b0;
		end else begin
			vend_req_act  <= 1'b0;
			err_setup_pkt <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (rd.hasdata) begin
						state <= ST_CHECK;
					end
				end
				ST_CHECK: begin
					if (ctr_start) begin
						state <= ST_READ;
					end else begin
						// Wrong length, flag it and drop the packet
						err_setup_pkt <= 1'b1;
						state         <= ST_RELEASE;
					end
				end
				ST_READ: begin
					if (ctr_done) begin
						state <= ST_DECODE;
					end
				end
				ST_DECODE: begin
					if (req_type == REQ_STANDARD && setup_b[1] == REQ_SET_ADDRESS) begin
						dev_addr <= setup_b[2][6:0];
					end else if (req_type == REQ_VENDOR) begin
						vend_req_act     <= 1'b1;
						vend_req_request <= setup_b[1];
						vend_req_val     <= {setup_b[3], setup_b[2]};
					end
					state <= ST_RELEASE;
				end
				// arm is high for this one cycle
				ST_RELEASE: state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/usb2_ep_buf.sv ====
////////////////////
// Single endpoint buffer with one packet of storage
// Writes are dropped while a packet is held (hasdata high)
// q is registered, one cycle behind rd_addr
// Commit on a full buffer or arm on an empty one is ignored
////////////////////

`default_nettype none

module usb2_ep_buf #(
	parameter int AW = usb2_pkg::BUF_AW
) (
	input  logic              phy_clk,
	input  logic              reset_2,
	usb2_buf_if.buffer        bus,
	input  logic              toggle_act,
	output usb2_pkg::toggle_e toggle
);
	import usb2_pkg::*;

	localparam int DEPTH = 1 << AW;

	logic [7:0]       mem [0:DEPTH-1];
	logic             full;
	logic [LEN_W-1:0] len_r;

	assign bus.ready   = ~full;
	assign bus.hasdata = full;
	assign bus.len     = len_r;

	////////////////////
	// Packet storage
	////////////////////

	always_ff @(posedge phy_clk) begin
		if (bus.wr_en && bus.ready) begin
			mem[bus.wr_addr] <= bus.wr_data;
		end
		bus.q <= mem[bus.rd_addr];
	end

	////////////////////
	// Ownership handover
	////////////////////

	always_ff @(posedge phy_clk) begin
		if (!reset_2) begin
			full           <= 1'b0;
			len_r          <= '0;
			bus.commit_ack <= 1'b0;
			bus.arm_ack    <= 1'b0;
		end else begin
			bus.commit_ack <= 1'b0;
			bus.arm_ack    <= 1'b0;
			// Writer hands the packet over
			if (bus.commit && !full) begin
				full           <= 1'b1;
				len_r          <= bus.commit_len;
				bus.commit_ack <= 1'b1;
			end else if (bus.arm && full) begin
				// Reader gives the buffer back
				full        <= 1'b0;
				bus.arm_ack <= 1'b1;
			end
		end
	end

	// DATA0/DATA1 sequence bit
	always_ff @(posedge phy_clk) begin
		if (!reset_2) begin
			toggle <= TOGGLE_DATA0;
		end else if (toggle_act) begin
			toggle <= (toggle == TOGGLE_DATA0) ? TOGGLE_DATA1 : TOGGLE_DATA0;
		end
	end

endmodule

`default_nettype wire

// ==== hw/usb2_pkg.sv ====
////////////////////
// Shared types and sizes for the USB 2.0 protocol layer
// Endpoint modes are fixed here and must match the descriptors
// Toggle values are a local 2-bit code, not the PID bits
////////////////////

`default_nettype none

package usb2_pkg;

	// Endpoint selectors on the packet side
	typedef enum logic [3:0] {
		SEL_ENDP0 = 4'd0,
		SEL_ENDP1 = 4'd1,
		SEL_ENDP2 = 4'd2
	} endp_sel_e;

	typedef enum logic [1:0] {
		EP_MODE_CONTROL   = 2'd0,
		EP_MODE_ISOCH     = 2'd1,
		EP_MODE_BULK      = 2'd2,
		EP_MODE_INTERRUPT = 2'd3
	} ep_mode_e;

	localparam ep_mode_e EP1_MODE = EP_MODE_BULK;
	localparam ep_mode_e EP2_MODE = EP_MODE_BULK;

	typedef enum logic [1:0] {
		TOGGLE_DATA0 = 2'd0,
		TOGGLE_DATA1 = 2'd1
	} toggle_e;

	localparam int BUF_AW    = 9;
	localparam int EP0_AW    = 6;
	localparam int LEN_W     = 10;
	localparam int SETUP_LEN = 8;

	// Type field of bmRequestType, bits 6:5
	typedef enum logic [1:0] {
		REQ_STANDARD = 2'd0,
		REQ_VENDOR   = 2'd2
	} req_type_e;

	localparam logic [7:0] REQ_SET_ADDRESS = 8'd5;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_CHECK,
		ST_READ,
		ST_DECODE,
		ST_RELEASE
	} ep0_state_e;

endpackage

`default_nettype wire

// ==== hw/usb2_protocol.sv ====
////////////////////
// USB 2.0 protocol layer, single clock
// Packet write port reaches EP0 and EP2, read port reaches EP1
// External side owns EP1 writes and EP2 reads, unmuxed
// Unselected outputs read as zero
////////////////////

`default_nettype none

module usb2_protocol (
	input  logic                         phy_clk,
	input  logic                         reset_2,
	input  logic [3:0]                   sel_endp,
	// Packet side
	input  logic [usb2_pkg::BUF_AW-1:0] buf_in_addr,
	input  logic [7:0]                   buf_in_data,
	input  logic                         buf_in_wren,
	output logic                         buf_in_ready,
	input  logic                         buf_in_commit,
	input  logic [usb2_pkg::LEN_W-1:0]  buf_in_commit_len,
	output logic                         buf_in_commit_ack,
	input  logic [usb2_pkg::BUF_AW-1:0] buf_out_addr,
	output logic [7:0]                   buf_out_q,
	output logic [usb2_pkg::LEN_W-1:0]  buf_out_len,
	output logic                         buf_out_hasdata,
	input  logic                         buf_out_arm,
	output logic                         buf_out_arm_ack,
	// External side
	input  logic [usb2_pkg::BUF_AW-1:0] ext_buf_in_addr,
	input  logic [7:0]                   ext_buf_in_data,
	input  logic                         ext_buf_in_wren,
	output logic                         ext_buf_in_ready,
	input  logic                         ext_buf_in_commit,
	input  logic [usb2_pkg::LEN_W-1:0]  ext_buf_in_commit_len,
	output logic                         ext_buf_in_commit_ack,
	input  logic [usb2_pkg::BUF_AW-1:0] ext_buf_out_addr,
	output logic [7:0]                   ext_buf_out_q,
	output logic [usb2_pkg::LEN_W-1:0]  ext_buf_out_len,
	output logic                         ext_buf_out_hasdata,
	input  logic                         ext_buf_out_arm,
	output logic                         ext_buf_out_arm_ack,
	// Status
	output logic [1:0]                   endp_mode,
	input  logic                         data_toggle_act,
	output logic [1:0]                   data_toggle,
	output logic                         vend_req_act,
	output logic [7:0]                   vend_req_request,
	output logic [15:0]                  vend_req_val,
	output logic [6:0]                   dev_addr,
	output logic                         err_setup_pkt
);
	import usb2_pkg::*;

	logic    sel0;
	logic    sel1;
	logic    sel2;
	toggle_e ep0_toggle;
	toggle_e ep1_toggle;
	toggle_e ep2_toggle;

	usb2_buf_if #(.AW(EP0_AW)) ep0_bus ();
	usb2_buf_if #(.AW(BUF_AW)) ep1_bus ();
	usb2_buf_if #(.AW(BUF_AW)) ep2_bus ();

	assign sel0 = (sel_endp == SEL_ENDP0);
	assign sel1 = (sel_endp == SEL_ENDP1);
	assign sel2 = (sel_endp == SEL_ENDP2);

	////////////////////
	// Endpoint input mux
	////////////////////

	assign ep0_bus.wr_addr    = sel0 ? buf_in_addr[EP0_AW-1:0] : '0;
	assign ep0_bus.wr_data    = sel0 ? buf_in_data : '0;
	assign ep0_bus.wr_en      = sel0 & buf_in_wren;
	assign ep0_bus.commit     = sel0 & buf_in_commit;
	assign ep0_bus.commit_len = sel0 ? buf_in_commit_len : '0;

	assign ep2_bus.wr_addr    = sel2 ? buf_in_addr : '0;
	assign ep2_bus.wr_data    = sel2 ? buf_in_data : '0;
	assign ep2_bus.wr_en      = sel2 & buf_in_wren;
	assign ep2_bus.commit     = sel2 & buf_in_commit;
	assign ep2_bus.commit_len = sel2 ? buf_in_commit_len : '0;

	assign ep1_bus.rd_addr    = sel1 ? buf_out_addr : '0;
	assign ep1_bus.arm        = sel1 & buf_out_arm;

	// External pins, no muxing
	assign ep1_bus.wr_addr    = ext_buf_in_addr;
	assign ep1_bus.wr_data    = ext_buf_in_data;
	assign ep1_bus.wr_en      = ext_buf_in_wren;
	assign ep1_bus.commit     = ext_buf_in_commit;
	assign ep1_bus.commit_len = ext_buf_in_commit_len;
	assign ep2_bus.rd_addr    = ext_buf_out_addr;
	assign ep2_bus.arm        = ext_buf_out_arm;

	////////////////////
	// Endpoint output mux
	////////////////////

	assign buf_in_ready      = sel0 ? ep0_bus.ready : sel2 ? ep2_bus.ready : 1'b0;
	assign buf_in_commit_ack = sel0 ? ep0_bus.commit_ack :
		sel2 ? ep2_bus.commit_ack : 1'b0;
	assign buf_out_q         = sel1 ? ep1_bus.q : '0;
	assign buf_out_len       = sel1 ? ep1_bus.len : '0;
	assign buf_out_hasdata   = sel1 & ep1_bus.hasdata;
	assign buf_out_arm_ack   = sel1 & ep1_bus.arm_ack;

	assign ext_buf_in_ready      = ep1_bus.ready;
	assign ext_buf_in_commit_ack = ep1_bus.commit_ack;
	assign ext_buf_out_q         = ep2_bus.q;
	assign ext_buf_out_len       = ep2_bus.len;
	assign ext_buf_out_hasdata   = ep2_bus.hasdata;
	assign ext_buf_out_arm_ack   = ep2_bus.arm_ack;

	assign endp_mode   = sel1 ? EP1_MODE : sel2 ? EP2_MODE : EP_MODE_CONTROL;
	assign data_toggle = sel0 ? ep0_toggle : sel1 ? ep1_toggle :
		sel2 ? ep2_toggle : 2'b00;

	////////////////////
	// Endpoints
	////////////////////

	usb2_ep_buf #(.AW(EP0_AW)) u_ep0_buf (
		.phy_clk    (phy_clk),
		.reset_2    (reset_2),
		.bus        (ep0_bus.buffer),
		.toggle_act (sel0 & data_toggle_act),
		.toggle     (ep0_toggle)
	);

	usb2_ep_buf #(.AW(BUF_AW)) u_ep1_buf (
		.phy_clk    (phy_clk),
		.reset_2    (reset_2),
		.bus        (ep1_bus.buffer),
		.toggle_act (sel1 & data_toggle_act),
		.toggle     (ep1_toggle)
	);

	usb2_ep_buf #(.AW(BUF_AW)) u_ep2_buf (
		.phy_clk    (phy_clk),
		.reset_2    (reset_2),
		.bus        (ep2_bus.buffer),
		.toggle_act (sel2 & data_toggle_act),
		.toggle     (ep2_toggle)
	);

	usb2_ep0_ctrl u_ep0_ctrl (
		.phy_clk          (phy_clk),
		.reset_2          (reset_2),
		.rd               (ep0_bus.reader),
		.vend_req_act     (vend_req_act),
		.vend_req_request (vend_req_request),
		.vend_req_val     (vend_req_val),
		.dev_addr         (dev_addr),
		.err_setup_pkt    (err_setup_pkt)
	);

endmodule

`default_nettype wire

// ==== hw/usb2_setup_ctr.sv ====
////////////////////
// Read address sequencer for the 8 setup bytes
// start is ignored while a sequence runs
////////////////////

`default_nettype none

module usb2_setup_ctr (
	input  logic                      phy_clk,
	input  logic                      reset_2,
	input  logic                      start,
	output logic [usb2_pkg::EP0_AW-1:0] addr,
	output logic                      busy,
	output logic                      done
);
	import usb2_pkg::*;

	always_ff @(posedge phy_clk) begin
		if (!reset_2) begin
			addr <= '0;
			busy <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start && !busy) begin
				addr <= '0;
				busy <= 1'b1;
			end else if (busy) begin
				// Last byte shows on q the cycle after, flag it then
				if (addr == EP0_AW'(SETUP_LEN - 1)) begin
					busy <= 1'b0;
					done <= 1'b1;
				end else begin
					addr <= addr + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== usb2_proto.f ====
hw/usb2_pkg.sv
hw/usb2_buf_if.sv
hw/usb2_ep_buf.sv
hw/usb2_setup_ctr.sv
hw/usb2_ep0_ctrl.sv
hw/usb2_protocol.sv
bench/usb2_protocol_tb.sv
